//--- fe_decode.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_decode (
	input  fe_pkg::fe_inst_meta_t  meta,
	output fe_pkg::fe_bcke_req_t   req,
	output fe_pkg::fe_wstall_t     wstall,
	output logic                   halt,
	output logic [`FE_NW_BITS-1:0] halt_wid
);
	import fe_pkg::*;

	logic [31:0] instr;
	logic [6:0]  opcode;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        is_ebreak;
	logic        is_ctl;

	assign instr  = meta.instr;
	assign opcode = instr[6:0];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign is_ebreak = meta.valid && (instr == ebreak_word);
	assign is_ctl    = meta.valid && (opcode inside {op_branch, op_jal, op_jalr});

	always_comb begin
		req             = '0;
		req.valid       = meta.valid && !is_ebreak; // A halted warp sends nothing on
		req.wid         = meta.wid;
		req.thread_mask = meta.thread_mask;
		req.pc          = meta.pc;
		req.opcode      = opcode;
		req.rd          = instr[11:7];
		req.func3       = instr[14:12];
		req.rs1         = instr[19:15];
		req.rs2         = instr[24:20];
		req.func7       = instr[31:25];
		req.is_branch   = (opcode == op_branch);
		req.is_jal      = (opcode == op_jal) || (opcode == op_jalr);
		req.is_load     = (opcode == op_load);
		req.is_store    = (opcode == op_store);
		req.is_alu      = opcode inside {op_alu, op_alui, op_lui, op_auipc};
		case (opcode)
			op_lui, op_auipc:                      req.imm = imm_u;
			op_jal:                                req.imm = imm_j;
			op_jalr, op_load, op_alui, op_system:  req.imm = imm_i;
			op_store:                              req.imm = imm_s;
			op_branch:                             req.imm = imm_b;
			default:                               req.imm = '0;
		endcase
	end

	// Control flow holds the warp in fetch until the back end answers
	always_comb begin
		wstall       = '0;
		wstall.valid = is_ctl;
		wstall.wid   = meta.wid;
	end

	assign halt     = is_ebreak;
	assign halt_wid = meta.wid;

endmodule

//--- fe_icache_stage.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_icache_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       schedule_delay,
	input  fe_pkg::fe_inst_meta_t      meta_in,
	output fe_pkg::fe_inst_meta_t      meta_out,
	output fe_pkg::fe_icache_req_t     icache_req,
	input  fe_pkg::fe_icache_rsp_t     icache_rsp,
	output logic                       icache_stage_delay,
	output logic [`FE_NW_BITS-1:0]     icache_stage_wid,
	output logic [`FE_NUM_THREADS-1:0] icache_stage_valids
);
	import fe_pkg::*;

	fe_inst_meta_t out_meta; // Meta of the request in flight
	fe_inst_meta_t rsp_meta;
	fe_inst_meta_t held_meta;
	logic          busy;
	logic          pending; // Response that came back under a freeze
	logic          issue;
	logic          rsp_fire;

	assign issue    = meta_in.valid && !busy && !schedule_delay;
	assign rsp_fire = icache_rsp.valid && busy;

	always_comb begin
		rsp_meta       = out_meta;
		rsp_meta.valid = 1'b1;
		rsp_meta.instr = icache_rsp.data;
	end

	always_comb begin
		icache_req       = '0;
		icache_req.valid = issue;
		icache_req.wid   = meta_in.wid;
		icache_req.addr  = meta_in.pc;
	end

	always_comb begin
		if (pending)
			meta_out = held_meta;
		else if (rsp_fire)
			meta_out = rsp_meta;
		else
			meta_out = '0;
	end

	// Stays high through the response cycle so f_i cannot load over its item
	assign icache_stage_delay  = busy;
	assign icache_stage_wid    = busy ? out_meta.wid : held_meta.wid;
	assign icache_stage_valids = busy ? out_meta.thread_mask :
		(pending ? held_meta.thread_mask : '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (issue)
				busy <= 1'b1;
			else if (rsp_fire)
				busy <= 1'b0;
			if (rsp_fire && schedule_delay)
				pending <= 1'b1;
			else if (!schedule_delay)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			out_meta <= meta_in;
		if (rsp_fire)
			held_meta <= rsp_meta;
	end

endmodule

//--- fe_macros.svh
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Number of warps scheduled by the front end
`define FE_NUM_WARPS 4

// Threads per warp, one valid bit each in a thread mask
`define FE_NUM_THREADS 4

// Width of a warp id, log2 of the warp count
`define FE_NW_BITS 2

// Word and PC width
`define FE_XLEN 32

`endif

//--- fe_pkg.sv
`include "fe_macros.svh"

package fe_pkg;

	typedef struct packed {
		logic                       spawn;
		logic [`FE_NW_BITS-1:0]     wid;
		logic [`FE_XLEN-1:0]        pc;
		logic [`FE_NUM_THREADS-1:0] thread_mask;
	} fe_warp_ctl_t;

	typedef struct packed {
		logic                       valid;
		logic [`FE_NW_BITS-1:0]     wid;
		logic [`FE_NUM_THREADS-1:0] thread_mask;
		logic [`FE_XLEN-1:0]        pc;
		logic [`FE_XLEN-1:0]        instr;
	} fe_inst_meta_t;

	typedef struct packed {
		logic                   valid;
		logic [`FE_NW_BITS-1:0] wid;
		logic [`FE_XLEN-1:0]    addr;
	} fe_icache_req_t;

	typedef struct packed {
		logic                   valid;
		logic [`FE_NW_BITS-1:0] wid;
		logic [`FE_XLEN-1:0]    data;
	} fe_icache_rsp_t;

	// Shared by the jal and the branch response
	typedef struct packed {
		logic                   valid;
		logic [`FE_NW_BITS-1:0] wid;
		logic                   taken;
		logic [`FE_XLEN-1:0]    target;
	} fe_ctl_rsp_t;

	typedef struct packed {
		logic                   valid;
		logic [`FE_NW_BITS-1:0] wid;
	} fe_wstall_t;

	typedef struct packed {
		logic                       valid;
		logic [`FE_NW_BITS-1:0]     wid;
		logic [`FE_NUM_THREADS-1:0] thread_mask;
		logic [`FE_XLEN-1:0]        pc;
		logic [6:0]                 opcode;
		logic [4:0]                 rd;
		logic [4:0]                 rs1;
		logic [4:0]                 rs2;
		logic [2:0]                 func3;
		logic [6:0]                 func7;
		logic [31:0]                imm;
		logic                       is_branch;
		logic                       is_jal; // Set for jalr as well
		logic                       is_load;
		logic                       is_store;
		logic                       is_alu;
	} fe_bcke_req_t;

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_alui   = 7'b0010011;
	localparam logic [6:0] op_alu    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

//--- fe_stage_reg.sv
`timescale 1ns/1ps

module fe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     freeze,
	input  payload_t d,
	output payload_t q
);

	// Valid bits live inside the payload, so the whole word is cleared
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else if (!freeze) begin
			q <= d;
		end
	end

endmodule

//--- fe_warp_fetch.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module fe_warp_fetch (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       schedule_delay,
	input  logic                       icache_stage_delay,
	input  logic [`FE_NW_BITS-1:0]     icache_stage_wid,
	input  logic [`FE_NUM_THREADS-1:0] icache_stage_valids,
	input  fe_pkg::fe_warp_ctl_t       warp_ctl,
	input  fe_pkg::fe_wstall_t         wstall,
	input  logic                       halt,
	input  logic [`FE_NW_BITS-1:0]     halt_wid,
	input  fe_pkg::fe_ctl_rsp_t        jal_rsp,
	input  fe_pkg::fe_ctl_rsp_t        branch_rsp,
	output fe_pkg::fe_inst_meta_t      fetch_meta,
	output logic                       fetch_ebreak
);

	logic [`FE_XLEN-1:0]        pc [`FE_NUM_WARPS];
	logic [`FE_NUM_THREADS-1:0] mask [`FE_NUM_WARPS];
	logic [`FE_NUM_WARPS-1:0]   active;
	logic [`FE_NUM_WARPS-1:0]   stalled; // Waiting for a jal or branch response
	logic [`FE_NUM_WARPS-1:0]   halted;
	logic [`FE_NUM_WARPS-1:0]   ready;
	logic                       started;
	logic                       fi_valid; // Copy of what the f_i register holds
	logic [`FE_NW_BITS-1:0]     fi_wid;
	logic [`FE_NW_BITS-1:0]     last_wid;
	logic [`FE_NW_BITS-1:0]     sel_wid;
	logic [`FE_NW_BITS-1:0]     cand;
	logic                       sel_found;
	logic                       hold;

	assign hold = schedule_delay || icache_stage_delay;

	always_comb begin
		for (int w = 0; w < `FE_NUM_WARPS; w++) begin
			ready[w] = active[w] && !stalled[w] && !halted[w];
			// A warp with an instruction between fetch and decode must wait for it
			if (fi_valid && fi_wid == w[`FE_NW_BITS-1:0])
				ready[w] = 1'b0;
			if (|icache_stage_valids && icache_stage_wid == w[`FE_NW_BITS-1:0])
				ready[w] = 1'b0;
			if (wstall.valid && wstall.wid == w[`FE_NW_BITS-1:0])
				ready[w] = 1'b0;
			if (halt && halt_wid == w[`FE_NW_BITS-1:0])
				ready[w] = 1'b0;
		end
	end

	// Round robin, starting after the warp picked last
	always_comb begin
		sel_found = 1'b0;
		sel_wid   = last_wid;
		cand      = last_wid;
		for (int i = 1; i <= `FE_NUM_WARPS; i++) begin
			cand = last_wid + i[`FE_NW_BITS-1:0];
			if (!sel_found && ready[cand]) begin
				sel_found = 1'b1;
				sel_wid   = cand;
			end
		end
	end

	always_comb begin
		fetch_meta             = '0;
		fetch_meta.valid       = sel_found;
		fetch_meta.wid         = sel_wid;
		fetch_meta.thread_mask = mask[sel_wid];
		fetch_meta.pc          = pc[sel_wid];
	end

	assign fetch_ebreak = started && (active == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= '0;
			stalled  <= '0;
			halted   <= '0;
			started  <= 1'b0;
			fi_valid <= 1'b0;
			fi_wid   <= '0;
			last_wid <= '0;
		end else begin
			if (!hold) begin
				fi_valid <= sel_found;
				fi_wid   <= sel_wid;
				if (sel_found)
					last_wid <= sel_wid;
			end
			if (wstall.valid)
				stalled[wstall.wid] <= 1'b1;
			if (jal_rsp.valid)
				stalled[jal_rsp.wid] <= 1'b0;
			if (branch_rsp.valid)
				stalled[branch_rsp.wid] <= 1'b0;
			if (halt) begin
				active[halt_wid] <= 1'b0;
				halted[halt_wid] <= 1'b1;
			end
			if (warp_ctl.spawn) begin
				active[warp_ctl.wid]  <= 1'b1;
				stalled[warp_ctl.wid] <= 1'b0;
				halted[warp_ctl.wid]  <= 1'b0;
				started               <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && sel_found)
			pc[sel_wid] <= pc[sel_wid] + `FE_XLEN'd4;
		if (jal_rsp.valid && jal_rsp.taken)
			pc[jal_rsp.wid] <= jal_rsp.target; // Fall through already in pc
		if (branch_rsp.valid && branch_rsp.taken)
			pc[branch_rsp.wid] <= branch_rsp.target;
		if (warp_ctl.spawn) begin
			pc[warp_ctl.wid]   <= warp_ctl.pc;
			mask[warp_ctl.wid] <= warp_ctl.thread_mask;
		end
	end

endmodule

//--- simt_front_end.f
+incdir+.
fe_pkg.sv
fe_stage_reg.sv
fe_warp_fetch.sv
fe_icache_stage.sv
fe_decode.sv
simt_front_end.sv
simt_front_end_props.sv
tb_simt_front_end.sv

//--- simt_front_end.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module simt_front_end (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   schedule_delay,
	input  fe_pkg::fe_warp_ctl_t   warp_ctl,
	output fe_pkg::fe_icache_req_t icache_req,
	input  fe_pkg::fe_icache_rsp_t icache_rsp,
	input  fe_pkg::fe_ctl_rsp_t    jal_rsp,
	input  fe_pkg::fe_ctl_rsp_t    branch_rsp,
	output fe_pkg::fe_bcke_req_t   bcke_req,
	output logic                   fetch_ebreak
);
	import fe_pkg::*;

	fe_inst_meta_t              fetch_meta;
	fe_inst_meta_t              fi_meta;
	fe_inst_meta_t              icache_meta;
	fe_inst_meta_t              id_meta;
	fe_bcke_req_t               decode_req;
	fe_wstall_t                 wstall;
	logic                       halt;
	logic [`FE_NW_BITS-1:0]     halt_wid;
	logic                       icache_stage_delay;
	logic [`FE_NW_BITS-1:0]     icache_stage_wid;
	logic [`FE_NUM_THREADS-1:0] icache_stage_valids;

	fe_warp_fetch fetch (
		.clk                (clk),
		.rst_n              (rst_n),
		.schedule_delay     (schedule_delay),
		.icache_stage_delay (icache_stage_delay),
		.icache_stage_wid   (icache_stage_wid),
		.icache_stage_valids(icache_stage_valids),
		.warp_ctl           (warp_ctl),
		.wstall             (wstall),
		.halt               (halt),
		.halt_wid           (halt_wid),
		.jal_rsp            (jal_rsp),
		.branch_rsp         (branch_rsp),
		.fetch_meta         (fetch_meta),
		.fetch_ebreak       (fetch_ebreak)
	);

	// The front of the pipe also waits on the cache
	fe_stage_reg #(.payload_t(fe_inst_meta_t)) f_i_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.freeze(schedule_delay || icache_stage_delay),
		.d     (fetch_meta),
		.q     (fi_meta)
	);

	fe_icache_stage icache_stage (
		.clk                (clk),
		.rst_n              (rst_n),
		.schedule_delay     (schedule_delay),
		.meta_in            (fi_meta),
		.meta_out           (icache_meta),
		.icache_req         (icache_req),
		.icache_rsp         (icache_rsp),
		.icache_stage_delay (icache_stage_delay),
		.icache_stage_wid   (icache_stage_wid),
		.icache_stage_valids(icache_stage_valids)
	);

	fe_stage_reg #(.payload_t(fe_inst_meta_t)) i_d_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.freeze(schedule_delay),
		.d     (icache_meta),
		.q     (id_meta)
	);

	fe_decode decode (
		.meta    (id_meta),
		.req     (decode_req),
		.wstall  (wstall),
		.halt    (halt),
		.halt_wid(halt_wid)
	);

	fe_stage_reg #(.payload_t(fe_bcke_req_t)) d_e_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.freeze(schedule_delay),
		.d     (decode_req),
		.q     (bcke_req)
	);

endmodule

//--- simt_front_end_props.sv
`timescale 1ns/1ps

module simt_front_end_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   schedule_delay,
	input logic                   icache_stage_delay,
	input fe_pkg::fe_icache_req_t icache_req,
	input fe_pkg::fe_icache_rsp_t icache_rsp,
	input fe_pkg::fe_bcke_req_t   bcke_req,
	input logic                   fetch_ebreak
);
	import fe_pkg::*;

	int   fail_cnt = 0; // Failed assertions so far
	logic req_open;     // A request is waiting for its response

	always_ff @(posedge clk) begin
		if (!rst_n)
			req_open <= 1'b0;
		else if (icache_req.valid)
			req_open <= 1'b1;
		else if (icache_rsp.valid)
			req_open <= 1'b0;
	end

	// A new request may only go out once the one before it is answered
	a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		icache_req.valid |-> !req_open)
		else begin
			fail_cnt++;
			$error("icache request issued while another is outstanding");
		end

	a_stable_on_freeze: assert property (@(posedge clk) disable iff (!rst_n)
		schedule_delay |=> $stable(bcke_req))
		else begin
			fail_cnt++;
			$error("bcke_req changed while schedule_delay was high");
		end

	// An ebreak never reaches the back end, so it is left out
	a_rsp_to_req: assert property (@(posedge clk) disable iff (!rst_n)
		(icache_rsp.valid && icache_stage_delay && !schedule_delay &&
		icache_rsp.data != ebreak_word) ##1 !schedule_delay |=> bcke_req.valid)
		else begin
			fail_cnt++;
			$error("bcke_req.valid did not follow the icache response");
		end

	a_reset_low: assert property (@(posedge clk)
		!rst_n ##1 !rst_n |-> !icache_req.valid && !bcke_req.valid &&
		!fetch_ebreak && !icache_stage_delay)
		else begin
			fail_cnt++;
			$error("an output was high during reset");
		end

endmodule

bind simt_front_end simt_front_end_props u_props (
	.clk               (clk),
	.rst_n             (rst_n),
	.schedule_delay    (schedule_delay),
	.icache_stage_delay(icache_stage_delay),
	.icache_req        (icache_req),
	.icache_rsp        (icache_rsp),
	.bcke_req          (bcke_req),
	.fetch_ebreak      (fetch_ebreak)
);

//--- tb_simt_front_end.sv
`timescale 1ns/1ps
`include "fe_macros.svh"

module tb_simt_front_end;
	import fe_pkg::*;

	logic           clk = 1'b0;
	logic           rst_n;
	logic           schedule_delay;
	fe_warp_ctl_t   warp_ctl;
	fe_icache_req_t icache_req;
	fe_icache_rsp_t icache_rsp;
	fe_ctl_rsp_t    jal_rsp;
	fe_ctl_rsp_t    branch_rsp;
	fe_bcke_req_t   bcke_req;
	logic           fetch_ebreak;

	integer      seed = 65223;
	logic [31:0] imem [256]; // Word index is pc[9:2]
	logic [31:0] exp_pc [`FE_NUM_WARPS]; // Next PC each warp must deliver
	logic [31:0] fetch_pc [`FE_NUM_WARPS]; // Next PC each warp must request
	logic [3:0]  wmask [`FE_NUM_WARPS];
	logic [`FE_NUM_WARPS-1:0] running;
	int          rsp_cnt [`FE_NUM_WARPS];
	logic        rsp_is_jal [`FE_NUM_WARPS];
	logic        rsp_taken [`FE_NUM_WARPS];
	logic [31:0] rsp_target [`FE_NUM_WARPS];
	logic        mem_busy;
	int          mem_cnt;
	logic [1:0]  mem_wid;
	logic [31:0] mem_addr;
	logic        freeze_en;
	int          freeze_cnt;
	logic        early_ebreak;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          err_at_start;

	simt_front_end u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.schedule_delay(schedule_delay),
		.warp_ctl      (warp_ctl),
		.icache_req    (icache_req),
		.icache_rsp    (icache_rsp),
		.jal_rsp       (jal_rsp),
		.branch_rsp    (branch_rsp),
		.bcke_req      (bcke_req),
		.fetch_ebreak  (fetch_ebreak)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] read_word(input logic [31:0] pc);
		return imem[pc[9:2]];
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// Expected back-end request, built from the RV32I field layout
	function automatic fe_bcke_req_t ref_decode(input logic [1:0] wid, input logic [3:0] mask,
			input logic [31:0] pc, input logic [31:0] w);
		fe_bcke_req_t r;
		logic [6:0]   op;
		op = w[6:0];
		r = '0;
		r.valid       = 1'b1;
		r.wid         = wid;
		r.thread_mask = mask;
		r.pc          = pc;
		r.opcode      = op;
		r.rd          = w[11:7];
		r.func3       = w[14:12];
		r.rs1         = w[19:15];
		r.rs2         = w[24:20];
		r.func7       = w[31:25];
		case (op)
			op_lui, op_auipc: r.imm = w & 32'hFFFF_F000;
			op_jal: r.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
			op_jalr, op_load, op_alui, op_system: r.imm = 32'($signed(w[31:20]));
			op_store: r.imm = 32'($signed({w[31:25], w[11:7]}));
			op_branch: r.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
			default: r.imm = '0;
		endcase
		r.is_branch = (op == op_branch);
		r.is_jal    = (op == op_jal) || (op == op_jalr);
		r.is_load   = (op == op_load);
		r.is_store  = (op == op_store);
		r.is_alu    = (op == op_alu) || (op == op_alui) || (op == op_lui) || (op == op_auipc);
		return r;
	endfunction

	// Where a warp fetches after pc, given the answers the back end will give
	function automatic logic [31:0] next_fetch(input logic [31:0] pc);
		fe_bcke_req_t d;
		d = ref_decode(2'd0, 4'h0, pc, read_word(pc));
		if (d.is_jal || (d.is_branch && d.func3 == 3'b000))
			return pc + d.imm;
		return pc + 32'd4;
	endfunction

	function automatic logic [31:0] random_plain();
		logic [31:0] r;
		int          sel;
		sel = {$random(seed)} % 6;
		r = $random(seed);
		case (sel)
			0: return {r[31:25] & 7'h20, r[24:12], r[11:7], op_alu};
			1: return enc_i(r[31:20], r[19:15], r[14:12], r[11:7], op_alui);
			2: return enc_i(r[31:20], r[19:15], 3'b010, r[11:7], op_load);
			3: return {r[31:25], r[24:15], 3'b010, r[11:7], op_store};
			4: return {r[31:12], r[11:7], op_lui};
			default: return {r[31:12], r[11:7], op_auipc};
		endcase
	endfunction

	task automatic load_straight(input int base, input int n);
		for (int i = 0; i < n; i++)
			imem[base + i] = random_plain();
		imem[base + n] = ebreak_word;
	endtask

	// beq is taken and bne falls through, so both branch paths are covered
	task automatic load_control(input int base);
		for (int i = 0; i < 12; i++)
			imem[base + i] = random_plain();
		imem[base + 1]  = enc_b(13'd12, 3'b000);
		imem[base + 5]  = enc_b(13'd8, 3'b001);
		imem[base + 7]  = enc_j(21'd8, 5'd1);
		imem[base + 9]  = enc_i(12'd8, 5'd3, 3'b000, 5'd1, op_jalr);
		imem[base + 12] = ebreak_word;
	endtask

	task automatic compare_value(input logic [255:0] got, input logic [255:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic spawn_warp(input int w, input logic [31:0] pc, input logic [3:0] mask);
		@(negedge clk);
		exp_pc[w]   = pc;
		fetch_pc[w] = pc;
		wmask[w]    = mask;
		running[w]  = (read_word(pc) != ebreak_word);
		warp_ctl.spawn       = 1'b1;
		warp_ctl.wid         = w[1:0];
		warp_ctl.pc          = pc;
		warp_ctl.thread_mask = mask;
		@(negedge clk);
		warp_ctl = '0;
	endtask

	function automatic logic rsp_pending();
		for (int w = 0; w < `FE_NUM_WARPS; w++)
			if (rsp_cnt[w] != 0)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic start_test();
		err_at_start = errors;
		early_ebreak = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int cyc;
		cyc = 0;
		while (!(fetch_ebreak && running == '0 && !rsp_pending()) && cyc < 3000) begin
			@(negedge clk);
			cyc++;
		end
		if (cyc >= 3000) begin
			errors++;
			$display("Timeout in %s: the warps did not all halt", name);
		end
		freeze_en = 1'b0;
		cyc = 0;
		while ((bcke_req.valid || mem_busy || schedule_delay) && cyc < 50) begin
			@(negedge clk);
			cyc++;
		end
		if (cyc >= 50) begin
			errors++;
			$display("Timeout in %s: the pipeline did not drain", name);
		end
		tests_run++;
		if (errors != err_at_start)
			tests_failed++;
		$display("Test %s: %s (%0d errors)", name,
			(errors == err_at_start) ? "ok" : "FAILED", errors - err_at_start);
	endtask

	// Consumes each request once, at the edge where d_e moves on
	always @(posedge clk) begin : monitor
		fe_bcke_req_t exp;
		logic [1:0]   w;
		logic [31:0]  next_pc;
		logic         taken;
		if (rst_n && icache_req.valid) begin
			if (mem_busy) begin
				errors++;
				$display("Second icache request at %0t while one was outstanding", $time);
			end
			mem_busy = 1'b1;
			mem_wid  = icache_req.wid;
			mem_addr = icache_req.addr;
			mem_cnt  = 1 + {$random(seed)} % 5;
			compare_value(icache_req.addr, fetch_pc[mem_wid],
				$sformatf("icache request of warp %0d", mem_wid));
			fetch_pc[mem_wid] = next_fetch(fetch_pc[mem_wid]);
		end
		if (rst_n && fetch_ebreak && running != '0 && !warp_ctl.spawn && !early_ebreak) begin
			errors++;
			early_ebreak = 1'b1;
			$display("fetch_ebreak rose at %0t while a warp was still running", $time);
		end
		if (rst_n && bcke_req.valid && !schedule_delay) begin
			w = bcke_req.wid;
			if (!running[w]) begin
				errors++;
				$display("Request at %0t for warp %0d, which should be halted", $time, w);
			end else begin
				exp = ref_decode(w, wmask[w], exp_pc[w], read_word(exp_pc[w]));
				compare_value(bcke_req, exp, $sformatf("warp %0d pc %h", w, exp_pc[w]));
				next_pc = exp_pc[w] + 32'd4;
				if (exp.is_branch || exp.is_jal) begin
					taken = exp.is_jal || (exp.func3 == 3'b000);
					rsp_cnt[w]    = 1 + {$random(seed)} % 4;
					rsp_is_jal[w] = exp.is_jal;
					rsp_taken[w]  = taken;
					rsp_target[w] = exp_pc[w] + exp.imm;
					if (taken)
						next_pc = rsp_target[w];
				end
				exp_pc[w] = next_pc;
				if (read_word(next_pc) == ebreak_word)
					running[w] = 1'b0;
			end
		end
	end

	always @(negedge clk) begin : driver
		icache_rsp = '0;
		jal_rsp    = '0;
		branch_rsp = '0;
		if (mem_busy) begin
			mem_cnt--;
			if (mem_cnt == 0) begin
				icache_rsp.valid = 1'b1;
				icache_rsp.wid   = mem_wid;
				icache_rsp.data  = read_word(mem_addr);
				mem_busy = 1'b0;
			end
		end
		for (int w = 0; w < `FE_NUM_WARPS; w++) begin
			if (rsp_cnt[w] > 1) begin
				rsp_cnt[w]--;
			end else if (rsp_cnt[w] == 1 && rsp_is_jal[w] && !jal_rsp.valid) begin
				jal_rsp = {1'b1, w[1:0], 1'b1, rsp_target[w]};
				rsp_cnt[w] = 0;
			end else if (rsp_cnt[w] == 1 && !rsp_is_jal[w] && !branch_rsp.valid) begin
				branch_rsp = {1'b1, w[1:0], rsp_taken[w], rsp_target[w]};
				rsp_cnt[w] = 0;
			end
		end
		if (freeze_en && freeze_cnt > 0) begin
			schedule_delay = 1'b1;
			freeze_cnt--;
		end else begin
			schedule_delay = 1'b0;
			if (freeze_en && {$random(seed)} % 4 == 0)
				freeze_cnt = 1 + {$random(seed)} % 4;
		end
	end

	initial begin
		rst_n = 1'b0;
		schedule_delay = 1'b0;
		warp_ctl   = '0;
		icache_rsp = '0;
		jal_rsp    = '0;
		branch_rsp = '0;
		running    = '0;
		mem_busy   = 1'b0;
		mem_cnt    = 0;
		freeze_en  = 1'b0;
		freeze_cnt = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int w = 0; w < `FE_NUM_WARPS; w++)
			rsp_cnt[w] = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = enc_i(12'(i * 3 + 1), 5'(i), 3'b000, 5'(i + 1), op_alui);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		start_test();
		load_straight(0, 12);
		spawn_warp(0, 32'h000, 4'hF);
		finish_test("single warp decode");

		start_test();
		for (int w = 0; w < 4; w++)
			load_straight(w * 64, 10 + w * 3);
		spawn_warp(0, 32'h000, 4'hF);
		spawn_warp(1, 32'h100, 4'h3);
		spawn_warp(2, 32'h200, 4'h1);
		spawn_warp(3, 32'h300, 4'hC);
		finish_test("round robin");

		start_test();
		for (int w = 0; w < 4; w++) begin
			load_control(w * 64);
			spawn_warp(w, 32'(w * 256), 4'hF);
		end
		finish_test("control flow");

		start_test();
		load_control(0);
		load_straight(64, 16);
		load_control(128);
		load_straight(192, 16);
		freeze_en = 1'b1;
		for (int w = 0; w < 4; w++)
			spawn_warp(w, 32'(w * 256), 4'h7);
		finish_test("freeze");

		start_test();
		load_straight(0, 0);
		load_straight(64, 3);
		load_straight(128, 9);
		load_control(192);
		for (int w = 0; w < 4; w++)
			spawn_warp(w, 32'(w * 256), 4'hF);
		finish_test("ebreak");

		errors += u_dut.u_props.fail_cnt; // Assertion failures count as errors too
		$display("Tests run %0d, failed %0d, checks %0d, assertion failures %0d, errors %0d",
			tests_run, tests_failed, checks, u_dut.u_props.fail_cnt, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
